// File: src/pext_op_pkg.sv
////////////////////
// Packed-SIMD opcode package
// Opcodes, unit and compare selects, decoded control
////////////////////
package pext_op_pkg;

  // Kept P-extension opcodes, byte and halfword forms side by side
  typedef enum logic [6:0] {
    ZPN_ADD8,      ZPN_ADD16,
    ZPN_SUB8,      ZPN_SUB16,
    ZPN_RADD8,     ZPN_RADD16,
    ZPN_URADD8,    ZPN_URADD16,
    ZPN_RSUB8,     ZPN_RSUB16,
    ZPN_URSUB8,    ZPN_URSUB16,
    ZPN_KADD8,     ZPN_KADD16,
    ZPN_UKADD8,    ZPN_UKADD16,
    ZPN_KSUB8,     ZPN_KSUB16,
    ZPN_UKSUB8,    ZPN_UKSUB16,
    ZPN_CMPEQ8,    ZPN_CMPEQ16,
    ZPN_SCMPLT8,   ZPN_SCMPLT16,
    ZPN_SCMPLE8,   ZPN_SCMPLE16,
    ZPN_UCMPLT8,   ZPN_UCMPLT16,
    ZPN_UCMPLE8,   ZPN_UCMPLE16,
    ZPN_SMIN8,     ZPN_SMIN16,
    ZPN_SMAX8,     ZPN_SMAX16,
    ZPN_UMIN8,     ZPN_UMIN16,
    ZPN_UMAX8,     ZPN_UMAX16,
    ZPN_SRA8,      ZPN_SRA16,
    ZPN_SRL8,      ZPN_SRL16,
    ZPN_SLL8,      ZPN_SLL16,
    ZPN_SRAI8,     ZPN_SRAI16,
    ZPN_SRLI8,     ZPN_SRLI16,
    ZPN_SLLI8,     ZPN_SLLI16,
    ZPN_SUNPKD810, ZPN_SUNPKD820, ZPN_SUNPKD830, ZPN_SUNPKD831, ZPN_SUNPKD832,
    ZPN_ZUNPKD810, ZPN_ZUNPKD820, ZPN_ZUNPKD830, ZPN_ZUNPKD831, ZPN_ZUNPKD832,
    ZPN_PKBB16,    ZPN_PKBT16,    ZPN_PKTB16,    ZPN_PKTT16
  } pext_op_e;

  // Which unit drives the result
  typedef enum logic [2:0] {
    UNIT_ADDER,
    UNIT_COMPARE,
    UNIT_MINMAX,
    UNIT_SHIFT,
    UNIT_PERMUTE
  } pext_unit_e;

  typedef enum logic [1:0] {
    CMP_EQ,
    CMP_LT,
    CMP_LE,
    CMP_GT
  } pext_cmp_e;

  // Decoded control, shared by all units
  typedef struct packed {
    pext_unit_e unit;
    logic       width8;
    logic       signed_ops;
    logic       sub;
    logic       halving;
    logic       saturate;
    pext_cmp_e  cmp_mode;
    logic       shift_left;
    logic       use_imm;
    pext_op_e   op;
  } pext_ctrl_t;

endpackage

// File: src/pext_lane_pkg.sv
////////////////////
// Packed-SIMD lane package
// Lane widths, saturation limits, operand pair
////////////////////
package pext_lane_pkg;

  parameter int LANE8_W  = 8;
  parameter int LANE16_W = 16;

  ////////////////////
  // Saturation limits
  ////////////////////
  parameter logic [LANE8_W-1:0]  SAT_U8_MAX  = 8'hff;
  parameter logic [LANE8_W-1:0]  SAT_S8_MIN  = 8'h80;
  parameter logic [LANE8_W-1:0]  SAT_S8_MAX  = 8'h7f;
  parameter logic [LANE16_W-1:0] SAT_U16_MAX = 16'hffff;
  parameter logic [LANE16_W-1:0] SAT_S16_MIN = 16'h8000;
  parameter logic [LANE16_W-1:0] SAT_S16_MAX = 16'h7fff;

  // Register pair as seen by every unit
  typedef struct packed {
    logic [31:0] a;
    logic [31:0] b;
  } pext_operands_t;

endpackage

// File: src/pext_decoder.sv
////////////////////
// Packed-SIMD opcode decoder
// Maps an opcode onto unit select and lane controls
////////////////////
module pext_decoder import pext_op_pkg::*; (
  input  pext_op_e   op_i,
  output pext_ctrl_t ctrl_o
);

  always_comb begin
    ctrl_o          = '0;
    ctrl_o.unit     = UNIT_ADDER;
    ctrl_o.cmp_mode = CMP_EQ;
    ctrl_o.op       = op_i;

    // Function and unit; unknown codes fall back to a plain wrapping add
    case (op_i)
      ZPN_SUB8, ZPN_SUB16: ctrl_o.sub = 1'b1;
      ZPN_RADD8, ZPN_RADD16, ZPN_URADD8, ZPN_URADD16: ctrl_o.halving = 1'b1;
      ZPN_RSUB8, ZPN_RSUB16, ZPN_URSUB8, ZPN_URSUB16: begin
        ctrl_o.halving = 1'b1;
        ctrl_o.sub     = 1'b1;
      end
      ZPN_KADD8, ZPN_KADD16, ZPN_UKADD8, ZPN_UKADD16: ctrl_o.saturate = 1'b1;
      ZPN_KSUB8, ZPN_KSUB16, ZPN_UKSUB8, ZPN_UKSUB16: begin
        ctrl_o.saturate = 1'b1;
        ctrl_o.sub      = 1'b1;
      end
      // Compares and min/max read the adder's difference
      ZPN_CMPEQ8, ZPN_CMPEQ16: begin
        ctrl_o.unit = UNIT_COMPARE;
        ctrl_o.sub  = 1'b1;
      end
      ZPN_SCMPLT8, ZPN_SCMPLT16, ZPN_UCMPLT8, ZPN_UCMPLT16: begin
        ctrl_o.unit     = UNIT_COMPARE;
        ctrl_o.sub      = 1'b1;
        ctrl_o.cmp_mode = CMP_LT;
      end
      ZPN_SCMPLE8, ZPN_SCMPLE16, ZPN_UCMPLE8, ZPN_UCMPLE16: begin
        ctrl_o.unit     = UNIT_COMPARE;
        ctrl_o.sub      = 1'b1;
        ctrl_o.cmp_mode = CMP_LE;
      end
      ZPN_SMIN8, ZPN_SMIN16, ZPN_UMIN8, ZPN_UMIN16: begin
        ctrl_o.unit     = UNIT_MINMAX;
        ctrl_o.sub      = 1'b1;
        ctrl_o.cmp_mode = CMP_LT;
      end
      ZPN_SMAX8, ZPN_SMAX16, ZPN_UMAX8, ZPN_UMAX16: begin
        ctrl_o.unit     = UNIT_MINMAX;
        ctrl_o.sub      = 1'b1;
        ctrl_o.cmp_mode = CMP_GT;
      end
      ZPN_SLL8, ZPN_SLL16, ZPN_SLLI8, ZPN_SLLI16: begin
        ctrl_o.unit       = UNIT_SHIFT;
        ctrl_o.shift_left = 1'b1;
      end
      ZPN_SRA8, ZPN_SRA16, ZPN_SRAI8, ZPN_SRAI16,
      ZPN_SRL8, ZPN_SRL16, ZPN_SRLI8, ZPN_SRLI16: ctrl_o.unit = UNIT_SHIFT;
      ZPN_SUNPKD810, ZPN_SUNPKD820, ZPN_SUNPKD830, ZPN_SUNPKD831, ZPN_SUNPKD832,
      ZPN_ZUNPKD810, ZPN_ZUNPKD820, ZPN_ZUNPKD830, ZPN_ZUNPKD831, ZPN_ZUNPKD832,
      ZPN_PKBB16, ZPN_PKBT16, ZPN_PKTB16, ZPN_PKTT16: ctrl_o.unit = UNIT_PERMUTE;
      default: ;
    endcase

    ctrl_o.use_imm = op_i inside {ZPN_SRAI8, ZPN_SRAI16, ZPN_SRLI8, ZPN_SRLI16,
                                  ZPN_SLLI8, ZPN_SLLI16};

    ctrl_o.signed_ops = op_i inside {ZPN_RADD8, ZPN_RADD16, ZPN_RSUB8, ZPN_RSUB16,
                                     ZPN_KADD8, ZPN_KADD16, ZPN_KSUB8, ZPN_KSUB16,
                                     ZPN_SCMPLT8, ZPN_SCMPLT16, ZPN_SCMPLE8, ZPN_SCMPLE16,
                                     ZPN_SMIN8, ZPN_SMIN16, ZPN_SMAX8, ZPN_SMAX16,
                                     ZPN_SRA8, ZPN_SRA16, ZPN_SRAI8, ZPN_SRAI16,
                                     ZPN_SUNPKD810, ZPN_SUNPKD820, ZPN_SUNPKD830,
                                     ZPN_SUNPKD831, ZPN_SUNPKD832};

    // Byte-lane forms
    ctrl_o.width8 = op_i inside {ZPN_ADD8, ZPN_SUB8, ZPN_RADD8, ZPN_URADD8, ZPN_RSUB8,
                                 ZPN_URSUB8, ZPN_KADD8, ZPN_UKADD8, ZPN_KSUB8, ZPN_UKSUB8,
                                 ZPN_CMPEQ8, ZPN_SCMPLT8, ZPN_SCMPLE8, ZPN_UCMPLT8,
                                 ZPN_UCMPLE8, ZPN_SMIN8, ZPN_SMAX8, ZPN_UMIN8, ZPN_UMAX8,
                                 ZPN_SRA8, ZPN_SRL8, ZPN_SLL8, ZPN_SRAI8, ZPN_SRLI8,
                                 ZPN_SLLI8};
  end

endmodule

// File: src/pext_lane_adder.sv
////////////////////
// Packed-SIMD lane adder
// Wrapping, halving and saturating add/sub per lane
////////////////////
module pext_lane_adder import pext_op_pkg::*, pext_lane_pkg::*; (
  input  pext_operands_t ops_i,
  input  pext_ctrl_t     ctrl_i,
  output logic [31:0]    sum_o,
  output logic [3:0]     sat_mask_o
);

  logic [3:0][LANE8_W:0] sum9;
  logic [3:0]            top;
  logic [3:0]            ovf;
  logic [31:0]           wrap_res;
  logic [31:0]           half_res;
  logic [31:0]           sat_res;

  ////////////////////
  // Byte adders
  ////////////////////
  for (genvar i = 0; i < 4; i++) begin : gen_byte
    logic [LANE8_W-1:0] a_byte;
    logic [LANE8_W-1:0] b_byte;
    logic               cin;
    logic               ext_a;
    logic               ext_b;

    assign a_byte = ops_i.a[i*LANE8_W +: LANE8_W];
    // Subtract as A + ~B + 1
    assign b_byte = ctrl_i.sub ? ~ops_i.b[i*LANE8_W +: LANE8_W]
                               : ops_i.b[i*LANE8_W +: LANE8_W];

    // Upper byte of a halfword takes the carry from below
    if (i % 2 == 1) begin : gen_upper
      assign cin = ctrl_i.width8 ? ctrl_i.sub : sum9[i-1][LANE8_W];
    end else begin : gen_lower
      assign cin = ctrl_i.sub;
    end

    assign sum9[i] = {1'b0, a_byte} + {1'b0, b_byte} + {{LANE8_W{1'b0}}, cin};

    // Ninth bit of the exact result, from the operand extensions
    assign ext_a  = ctrl_i.signed_ops & a_byte[LANE8_W-1];
    assign ext_b  = ctrl_i.signed_ops ? b_byte[LANE8_W-1] : ctrl_i.sub;
    assign top[i] = ext_a ^ ext_b ^ sum9[i][LANE8_W];

    // Signed overflow when the exact sign differs from the lane MSB
    assign ovf[i] = ctrl_i.signed_ops ? (top[i] ^ sum9[i][LANE8_W-1]) : top[i];
  end

  ////////////////////
  // Result forms
  ////////////////////
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      wrap_res[i*LANE8_W +: LANE8_W] = sum9[i][LANE8_W-1:0];
    end

    if (ctrl_i.width8) begin
      for (int i = 0; i < 4; i++) begin
        half_res[i*LANE8_W +: LANE8_W] = {top[i], sum9[i][LANE8_W-1:1]};
        if (!ovf[i]) begin
          sat_res[i*LANE8_W +: LANE8_W] = sum9[i][LANE8_W-1:0];
        end else if (ctrl_i.signed_ops) begin
          sat_res[i*LANE8_W +: LANE8_W] = top[i] ? SAT_S8_MIN : SAT_S8_MAX;
        end else begin
          sat_res[i*LANE8_W +: LANE8_W] = ctrl_i.sub ? {LANE8_W{1'b0}} : SAT_U8_MAX;
        end
      end
      sat_mask_o = ovf;
    end else begin
      for (int h = 0; h < 2; h++) begin
        half_res[h*LANE16_W +: LANE16_W] = {top[2*h+1], sum9[2*h+1][LANE8_W-1:0],
                                            sum9[2*h][LANE8_W-1:1]};
        if (!ovf[2*h+1]) begin
          sat_res[h*LANE16_W +: LANE16_W] = {sum9[2*h+1][LANE8_W-1:0],
                                             sum9[2*h][LANE8_W-1:0]};
        end else if (ctrl_i.signed_ops) begin
          sat_res[h*LANE16_W +: LANE16_W] = top[2*h+1] ? SAT_S16_MIN : SAT_S16_MAX;
        end else begin
          sat_res[h*LANE16_W +: LANE16_W] = ctrl_i.sub ? {LANE16_W{1'b0}} : SAT_U16_MAX;
        end
      end
      // Halfword flag covers both of its bytes
      sat_mask_o = {ovf[3], ovf[3], ovf[1], ovf[1]};
    end
  end

  always_comb begin
    if (ctrl_i.saturate) begin
      sum_o = sat_res;
    end else if (ctrl_i.halving) begin
      sum_o = half_res;
    end else begin
      sum_o = wrap_res;
    end
  end

endmodule

// File: src/pext_compare.sv
////////////////////
// Packed-SIMD lane compare
// Lane masks and min/max from the A-B difference
////////////////////
module pext_compare import pext_op_pkg::*, pext_lane_pkg::*; (
  input  pext_operands_t ops_i,
  input  pext_ctrl_t     ctrl_i,
  input  logic [31:0]    diff_i,
  output logic [31:0]    cmp_o,
  output logic [31:0]    minmax_o
);

  logic [3:0] byte_eq;
  logic [3:0] byte_lt;
  logic [3:0] lane_eq;
  logic [3:0] lane_lt;
  logic [3:0] holds;

  // Per-byte relations
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      byte_eq[i] = (diff_i[i*LANE8_W +: LANE8_W] == {LANE8_W{1'b0}});
      if (ops_i.a[i*LANE8_W+LANE8_W-1] == ops_i.b[i*LANE8_W+LANE8_W-1]) begin
        // Same sign, so the difference cannot overflow
        byte_lt[i] = diff_i[i*LANE8_W+LANE8_W-1];
      end else begin
        byte_lt[i] = ctrl_i.signed_ops ? ops_i.a[i*LANE8_W+LANE8_W-1]
                                       : ops_i.b[i*LANE8_W+LANE8_W-1];
      end
    end
  end

  // Halfword lanes take less from the upper byte
  always_comb begin
    if (ctrl_i.width8) begin
      lane_eq = byte_eq;
      lane_lt = byte_lt;
    end else begin
      lane_eq = {{2{&byte_eq[3:2]}}, {2{&byte_eq[1:0]}}};
      lane_lt = {{2{byte_lt[3]}}, {2{byte_lt[1]}}};
    end
  end

  always_comb begin
    case (ctrl_i.cmp_mode)
      CMP_LT:  holds = lane_lt;
      CMP_LE:  holds = lane_eq | lane_lt;
      CMP_GT:  holds = ~(lane_eq | lane_lt);
      default: holds = lane_eq;
    endcase
  end

  ////////////////////
  // Lane outputs
  ////////////////////
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      cmp_o[i*LANE8_W +: LANE8_W]    = {LANE8_W{holds[i]}};
      minmax_o[i*LANE8_W +: LANE8_W] = holds[i] ? ops_i.a[i*LANE8_W +: LANE8_W]
                                                : ops_i.b[i*LANE8_W +: LANE8_W];
    end
  end

endmodule

// File: src/pext_shifter.sv
////////////////////
// Packed-SIMD lane shifter
// Byte and halfword shifts, left done by bit reversal
////////////////////
module pext_shifter import pext_op_pkg::*, pext_lane_pkg::*; (
  input  pext_operands_t ops_i,
  input  pext_ctrl_t     ctrl_i,
  input  logic [4:0]     imm_i,
  output logic [31:0]    shift_o
);

  logic [3:0]  amt;
  logic        arith;
  logic [31:0] src;
  logic [31:0] lanes8;
  logic [31:0] lanes16;
  logic [31:0] shr;

  function automatic logic [31:0] bit_reverse(input logic [31:0] x);
    logic [31:0] y;
    for (int i = 0; i < 32; i++) begin
      y[i] = x[31-i];
    end
    return y;
  endfunction

  // Byte lanes use the low 3 bits only
  assign amt   = ctrl_i.use_imm ? imm_i[3:0] : ops_i.b[3:0];
  assign arith = ctrl_i.signed_ops & ~ctrl_i.shift_left;
  assign src   = ctrl_i.shift_left ? bit_reverse(ops_i.a) : ops_i.a;

  ////////////////////
  // Right shifters
  ////////////////////
  always_comb begin
    logic [LANE8_W:0]  ext8;
    logic [LANE8_W:0]  res8;
    logic [LANE16_W:0] ext16;
    logic [LANE16_W:0] res16;

    for (int i = 0; i < 4; i++) begin
      ext8  = {arith & src[i*LANE8_W+LANE8_W-1], src[i*LANE8_W +: LANE8_W]};
      res8  = $signed(ext8) >>> amt[2:0];
      lanes8[i*LANE8_W +: LANE8_W] = res8[LANE8_W-1:0];
    end

    for (int h = 0; h < 2; h++) begin
      ext16 = {arith & src[h*LANE16_W+LANE16_W-1], src[h*LANE16_W +: LANE16_W]};
      res16 = $signed(ext16) >>> amt;
      lanes16[h*LANE16_W +: LANE16_W] = res16[LANE16_W-1:0];
    end
  end

  assign shr = ctrl_i.width8 ? lanes8 : lanes16;

  // Undo the reversal for left shifts
  assign shift_o = ctrl_i.shift_left ? bit_reverse(shr) : shr;

endmodule

// File: src/pext_permute.sv
////////////////////
// Packed-SIMD permute
// Byte unpack with extension, halfword pack
////////////////////
module pext_permute import pext_op_pkg::*, pext_lane_pkg::*; (
  input  pext_operands_t ops_i,
  input  pext_ctrl_t     ctrl_i,
  output logic [31:0]    perm_o
);

  logic [1:0]          lo_sel;
  logic [1:0]          hi_sel;
  logic                pack;
  logic                a_top;
  logic                b_top;
  logic [LANE8_W-1:0]  lo_byte;
  logic [LANE8_W-1:0]  hi_byte;
  logic [LANE16_W-1:0] a_half;
  logic [LANE16_W-1:0] b_half;

  // Byte and half selection from the opcode
  always_comb begin
    lo_sel = 2'd0;
    hi_sel = 2'd1;
    pack   = 1'b0;
    a_top  = 1'b0;
    b_top  = 1'b0;
    case (ctrl_i.op)
      ZPN_SUNPKD820, ZPN_ZUNPKD820: hi_sel = 2'd2;
      ZPN_SUNPKD830, ZPN_ZUNPKD830: hi_sel = 2'd3;
      ZPN_SUNPKD831, ZPN_ZUNPKD831: begin
        lo_sel = 2'd1;
        hi_sel = 2'd3;
      end
      ZPN_SUNPKD832, ZPN_ZUNPKD832: begin
        lo_sel = 2'd2;
        hi_sel = 2'd3;
      end
      ZPN_PKBB16: pack = 1'b1;
      ZPN_PKBT16: begin
        pack  = 1'b1;
        b_top = 1'b1;
      end
      ZPN_PKTB16: begin
        pack  = 1'b1;
        a_top = 1'b1;
      end
      ZPN_PKTT16: begin
        pack  = 1'b1;
        a_top = 1'b1;
        b_top = 1'b1;
      end
      default: ;
    endcase
  end

  assign lo_byte = ops_i.a[lo_sel*LANE8_W +: LANE8_W];
  assign hi_byte = ops_i.a[hi_sel*LANE8_W +: LANE8_W];
  assign a_half  = a_top ? ops_i.a[31:16] : ops_i.a[15:0];
  assign b_half  = b_top ? ops_i.b[31:16] : ops_i.b[15:0];

  assign perm_o = pack ? {a_half, b_half}
                       : {{LANE8_W{ctrl_i.signed_ops & hi_byte[LANE8_W-1]}}, hi_byte,
                          {LANE8_W{ctrl_i.signed_ops & lo_byte[LANE8_W-1]}}, lo_byte};

endmodule

// File: src/pext_alu.sv
////////////////////
// Packed-SIMD ALU top
// Decode, lane units, result select, output register
////////////////////
module pext_alu import pext_op_pkg::*, pext_lane_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        enable_i,
  input  pext_op_e    op_i,
  input  logic [31:0] operand_a_i,
  input  logic [31:0] operand_b_i,
  input  logic [4:0]  imm_i,
  output logic [31:0] result_o,
  output logic        set_ov_o,
  output logic        valid_o
);

  pext_ctrl_t     ctrl;
  pext_operands_t ops;
  logic [31:0]    sum;
  logic [3:0]     sat_mask;
  logic [31:0]    cmp;
  logic [31:0]    minmax;
  logic [31:0]    shift;
  logic [31:0]    perm;
  logic [31:0]    result_d;
  logic           ov_d;

  assign ops.a = operand_a_i;
  assign ops.b = operand_b_i;

  pext_decoder u_decoder (
    .op_i   (op_i),
    .ctrl_o (ctrl)
  );

  pext_lane_adder u_adder (
    .ops_i      (ops),
    .ctrl_i     (ctrl),
    .sum_o      (sum),
    .sat_mask_o (sat_mask)
  );

  // Compare ops decode to a plain subtract, so sum is the wrapped difference
  pext_compare u_compare (
    .ops_i    (ops),
    .ctrl_i   (ctrl),
    .diff_i   (sum),
    .cmp_o    (cmp),
    .minmax_o (minmax)
  );

  pext_shifter u_shifter (
    .ops_i   (ops),
    .ctrl_i  (ctrl),
    .imm_i   (imm_i),
    .shift_o (shift)
  );

  pext_permute u_permute (
    .ops_i  (ops),
    .ctrl_i (ctrl),
    .perm_o (perm)
  );

  ////////////////////
  // Result select
  ////////////////////
  always_comb begin
    case (ctrl.unit)
      UNIT_COMPARE: result_d = cmp;
      UNIT_MINMAX:  result_d = minmax;
      UNIT_SHIFT:   result_d = shift;
      UNIT_PERMUTE: result_d = perm;
      default:      result_d = sum;
    endcase
  end

  assign ov_d = ctrl.saturate & (|sat_mask);

  // One-cycle output stage, result holds while idle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      result_o <= '0;
      set_ov_o <= 1'b0;
      valid_o  <= 1'b0;
    end else begin
      valid_o <= enable_i;
      if (enable_i) begin
        result_o <= result_d;
        set_ov_o <= ov_d;
      end
    end
  end

endmodule

// File: tests/tb_clock.sv
////////////////////
// Testbench clock and reset source
////////////////////
module tb_clock #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release lands just after an edge, like the other inputs
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2 rst_n_o = 1'b1;
  end

endmodule

// File: tests/pext_alu_assert.sv
////////////////////
// Packed-SIMD ALU checker
// Lane reference model and output timing assertions
////////////////////
module pext_alu_assert import pext_op_pkg::*; (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        enable_i,
  input pext_op_e    op_i,
  input logic [31:0] operand_a_i,
  input logic [31:0] operand_b_i,
  input logic [4:0]  imm_i,
  input logic [31:0] result_o,
  input logic        set_ov_o,
  input logic        valid_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [32:0] exp_q;
  pext_op_e    exp_op;

  // Last failure, read by the testbench
  int          fail_count = 0;
  int          fail_kind  = 0;
  logic [31:0] bad_exp    = '0;
  logic [31:0] bad_act    = '0;
  pext_op_e    bad_op     = ZPN_ADD8;

  function automatic logic [31:0] unpack(input logic [31:0] a, input int hi_b,
                                         input int lo_b, input logic sgn);
    logic [7:0] h;
    logic [7:0] l;
    h = a[hi_b*8 +: 8];
    l = a[lo_b*8 +: 8];
    return {{8{sgn & h[7]}}, h, {8{sgn & l[7]}}, l};
  endfunction

  ////////////////////
  // Reference model
  ////////////////////
  // Bit 32 is the expected overflow flag
  function automatic logic [32:0] model(input pext_op_e op, input logic [31:0] a,
                                        input logic [31:0] b, input logic [4:0] imm);
    int          w;
    int          mask;
    int          x;
    int          y;
    int          r;
    int          lo;
    int          hi;
    int          amt;
    logic        sgn;
    logic        ov;
    logic [31:0] res;
    logic [31:0] lane;
    case (op)
      ZPN_PKBB16:    return {1'b0, a[15:0], b[15:0]};
      ZPN_PKBT16:    return {1'b0, a[15:0], b[31:16]};
      ZPN_PKTB16:    return {1'b0, a[31:16], b[15:0]};
      ZPN_PKTT16:    return {1'b0, a[31:16], b[31:16]};
      ZPN_SUNPKD810: return {1'b0, unpack(a, 1, 0, 1'b1)};
      ZPN_SUNPKD820: return {1'b0, unpack(a, 2, 0, 1'b1)};
      ZPN_SUNPKD830: return {1'b0, unpack(a, 3, 0, 1'b1)};
      ZPN_SUNPKD831: return {1'b0, unpack(a, 3, 1, 1'b1)};
      ZPN_SUNPKD832: return {1'b0, unpack(a, 3, 2, 1'b1)};
      ZPN_ZUNPKD810: return {1'b0, unpack(a, 1, 0, 1'b0)};
      ZPN_ZUNPKD820: return {1'b0, unpack(a, 2, 0, 1'b0)};
      ZPN_ZUNPKD830: return {1'b0, unpack(a, 3, 0, 1'b0)};
      ZPN_ZUNPKD831: return {1'b0, unpack(a, 3, 1, 1'b0)};
      ZPN_ZUNPKD832: return {1'b0, unpack(a, 3, 2, 1'b0)};
      default: ;
    endcase

    // Lane forms come in pairs, byte form on even codes
    w    = op[0] ? 16 : 8;
    mask = (1 << w) - 1;
    sgn  = op inside {ZPN_RADD8, ZPN_RADD16, ZPN_RSUB8, ZPN_RSUB16, ZPN_KADD8, ZPN_KADD16,
                      ZPN_KSUB8, ZPN_KSUB16, ZPN_SCMPLT8, ZPN_SCMPLT16, ZPN_SCMPLE8,
                      ZPN_SCMPLE16, ZPN_SMIN8, ZPN_SMIN16, ZPN_SMAX8, ZPN_SMAX16,
                      ZPN_SRA8, ZPN_SRA16, ZPN_SRAI8, ZPN_SRAI16};
    amt  = (op inside {[ZPN_SRAI8:ZPN_SLLI16]}) ? int'(imm[3:0]) : int'(b[3:0]);
    amt  = amt & (w - 1);
    lo   = sgn ? -(1 << (w - 1)) : 0;
    hi   = sgn ? (1 << (w - 1)) - 1 : mask;
    res  = '0;
    ov   = 1'b0;

    for (int i = 0; i < 32 / w; i++) begin
      x = int'(a >> (i * w)) & mask;
      y = int'(b >> (i * w)) & mask;
      if (sgn && x > hi) x = x - (1 << w);
      if (sgn && y > hi) y = y - (1 << w);
      case (op)
        ZPN_ADD8, ZPN_ADD16, ZPN_KADD8, ZPN_KADD16, ZPN_UKADD8, ZPN_UKADD16: r = x + y;
        ZPN_SUB8, ZPN_SUB16, ZPN_KSUB8, ZPN_KSUB16, ZPN_UKSUB8, ZPN_UKSUB16: r = x - y;
        ZPN_RADD8, ZPN_RADD16, ZPN_URADD8, ZPN_URADD16: r = (x + y) >>> 1;
        ZPN_RSUB8, ZPN_RSUB16, ZPN_URSUB8, ZPN_URSUB16: r = (x - y) >>> 1;
        ZPN_CMPEQ8, ZPN_CMPEQ16: r = (x == y) ? -1 : 0;
        ZPN_SCMPLT8, ZPN_SCMPLT16, ZPN_UCMPLT8, ZPN_UCMPLT16: r = (x < y) ? -1 : 0;
        ZPN_SCMPLE8, ZPN_SCMPLE16, ZPN_UCMPLE8, ZPN_UCMPLE16: r = (x <= y) ? -1 : 0;
        ZPN_SMIN8, ZPN_SMIN16, ZPN_UMIN8, ZPN_UMIN16: r = (x < y) ? x : y;
        ZPN_SMAX8, ZPN_SMAX16, ZPN_UMAX8, ZPN_UMAX16: r = (x > y) ? x : y;
        ZPN_SRA8, ZPN_SRA16, ZPN_SRAI8, ZPN_SRAI16: r = x >>> amt;
        ZPN_SRL8, ZPN_SRL16, ZPN_SRLI8, ZPN_SRLI16: r = x >> amt;
        ZPN_SLL8, ZPN_SLL16, ZPN_SLLI8, ZPN_SLLI16: r = x << amt;
        default: r = 0;
      endcase
      // Saturating forms clamp to the lane range
      if (op inside {[ZPN_KADD8:ZPN_UKSUB16]}) begin
        if (r > hi) begin
          r  = hi;
          ov = 1'b1;
        end else if (r < lo) begin
          r  = lo;
          ov = 1'b1;
        end
      end
      lane = 32'(r & mask);
      res  = res | (lane << (i * w));
    end
    return {ov, res};
  endfunction

  function automatic void note_failure(input int kind, input logic [31:0] exp_v,
                                       input logic [31:0] act_v, input pext_op_e op);
    fail_kind  = kind;
    bad_exp    = exp_v;
    bad_act    = act_v;
    bad_op     = op;
    fail_count = fail_count + 1;
  endfunction

  // Expected outputs of the operation accepted at this edge
  always_ff @(posedge clk_i) begin
    if (enable_i) begin
      exp_q  <= model(op_i, operand_a_i, operand_b_i, imm_i);
      exp_op <= op_i;
    end
  end

  ////////////////////
  // Assertions
  ////////////////////
  a_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    enable_i |=> result_o == exp_q[31:0])
  else begin
    note_failure(1, $sampled(exp_q[31:0]), $sampled(result_o), $sampled(exp_op));
    $error("result_o mismatch");
  end

  a_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    enable_i |=> set_ov_o == exp_q[32])
  else begin
    note_failure(2, {31'd0, $sampled(exp_q[32])}, {31'd0, $sampled(set_ov_o)},
                 $sampled(exp_op));
    $error("set_ov_o mismatch");
  end

  a_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ##1 valid_o == $past(enable_i))
  else begin
    note_failure(3, '0, '0, $sampled(exp_op));
    $error("valid_o does not follow enable_i");
  end

  a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !enable_i |=> $stable(result_o))
  else begin
    note_failure(4, '0, '0, $sampled(exp_op));
    $error("result_o changed while idle");
  end

  a_reset: assert property (@(posedge clk_i)
    !rst_n_i |=> (!valid_o && !set_ov_o && result_o == '0))
  else begin
    note_failure(5, '0, '0, $sampled(exp_op));
    $error("outputs not cleared by reset");
  end

endmodule

bind pext_alu pext_alu_assert u_checks (.*);

// File: tests/tb_pext_alu.sv
////////////////////
// Packed-SIMD ALU testbench
// Walks every opcode with corner and LFSR operands
////////////////////
module tb_pext_alu import pext_op_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int DRIVE_DELAY = 2;
  localparam int WAIT_LIMIT  = 50;

  logic        clk;
  logic        rst_n;
  logic        enable;
  pext_op_e    op;
  logic [31:0] operand_a;
  logic [31:0] operand_b;
  logic [4:0]  imm;
  logic [31:0] result;
  logic        set_ov;
  logic        valid;

  logic [31:0] lfsr  = 32'h9ea5_d144;
  string       group = "reset";

  tb_clock #(
    .PERIOD_NS    (20),
    .RESET_CYCLES (8)
  ) u_clock (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  pext_alu pext_alu_inst (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .enable_i    (enable),
    .op_i        (op),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .imm_i       (imm),
    .result_o    (result),
    .set_ov_o    (set_ov),
    .valid_o     (valid)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic report_error();
    pext_op_e bad;
    int       kind;
    bad  = pext_alu_inst.u_checks.bad_op;
    kind = pext_alu_inst.u_checks.fail_kind;
    case (kind)
      1, 2: $display("FAIL %s/%s %s expected %h actual %h", group, bad.name(),
                     (kind == 2) ? "set_ov" : "result",
                     pext_alu_inst.u_checks.bad_exp, pext_alu_inst.u_checks.bad_act);
      3: $display("valid_o did not follow enable_i one cycle later in %s", group);
      4: $display("result_o changed while no operation was issued in %s", group);
      default: $display("Outputs were not cleared by reset");
    endcase
    $display("Finished with errors");
    $fatal(1, "Stopped at the first failed check");
  endtask

  task automatic timeout_stop(input string what);
    $display("Timed out waiting for %s", what);
    $display("Finished with errors");
    $fatal(1, "Stopped on timeout");
  endtask

  // First failed assertion ends the run
  always @(pext_alu_inst.u_checks.fail_count) begin
    if (pext_alu_inst.u_checks.fail_count != 0) begin
      report_error();
    end
  end

  ////////////////////
  // Drive helpers
  ////////////////////
  task automatic issue(input pext_op_e code, input logic [31:0] a, input logic [31:0] b,
                       input logic [4:0] amount);
    enable    = 1'b1;
    op        = code;
    operand_a = a;
    operand_b = b;
    imm       = amount;
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  // Idle cycle, the inputs still move underneath
  task automatic gap(input pext_op_e code, input logic [31:0] a, input logic [31:0] b);
    enable    = 1'b0;
    op        = code;
    operand_a = a;
    operand_b = b;
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic wait_valid(input logic level, input string what);
    int cycles;
    cycles = 0;
    while (valid !== level && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      #DRIVE_DELAY;
      cycles++;
    end
    if (valid !== level) begin
      timeout_stop(what);
    end
  endtask

  task automatic end_burst(input string name);
    wait_valid(1'b1, {name, " last result"});
    enable = 1'b0;
    wait_valid(1'b0, {name, " idle"});
  endtask

  // Two corner pairs, then three random pairs per opcode
  task automatic run_group(input string name, input pext_op_e first, input pext_op_e last,
                           input logic [31:0] ca0, input logic [31:0] cb0,
                           input logic [31:0] ca1, input logic [31:0] cb1);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] amount;
    group = name;
    for (int k = first; k <= last; k++) begin
      issue(pext_op_e'(k), ca0, cb0, 5'd0);
      issue(pext_op_e'(k), ca1, cb1, 5'h0f);
      repeat (3) begin
        take_bits(32, a);
        take_bits(32, b);
        take_bits(5, amount);
        issue(pext_op_e'(k), a, b, amount[4:0]);
      end
    end
    end_burst(name);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    logic [31:0] code;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] bit_v;
    int          cycles;

    enable    = 1'b0;
    op        = ZPN_ADD8;
    operand_a = '0;
    operand_b = '0;
    imm       = '0;

    cycles = 0;
    while (!rst_n && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (!rst_n) begin
      timeout_stop("reset release");
    end
    @(posedge clk);
    #DRIVE_DELAY;

    run_group("wrap", ZPN_ADD8, ZPN_SUB16, 32'h7f80_ff01, 32'h0180_0102,
              32'h7fff_8000, 32'h0001_8000);
    run_group("halving", ZPN_RADD8, ZPN_URSUB16, 32'hff80_7f00, 32'h0180_8001,
              32'h8000_7fff, 32'h8000_ffff);
    run_group("saturate", ZPN_KADD8, ZPN_UKSUB16, 32'h7f80_7f80, 32'h0180_ff01,
              32'h7fff_8000, 32'h0001_ffff);
    run_group("compare", ZPN_CMPEQ8, ZPN_UMAX16, 32'h1234_80ff, 32'h1234_7fff,
              32'h8000_7fff, 32'h7fff_8000);
    run_group("shift", ZPN_SRA8, ZPN_SLLI16, 32'h80ff_7f01, 32'h0000_0000,
              32'h8001_ff7f, 32'h0000_000f);
    run_group("permute", ZPN_SUNPKD810, ZPN_PKTT16, 32'h8081_7f01, 32'hff00_1234,
              32'h7f80_00ff, 32'h8000_7fff);

    // Random opcodes with idle gaps between them
    group = "mixed";
    repeat (24) begin
      take_bits(6, code);
      take_bits(32, a);
      take_bits(32, b);
      take_bits(1, bit_v);
      if (bit_v[0]) begin
        issue(pext_op_e'(code[5:0]), a, b, a[4:0]);
      end else begin
        gap(pext_op_e'(code[5:0]), a, b);
      end
    end
    issue(ZPN_KADD16, 32'h7fff_7fff, 32'h7fff_0001, 5'd0);
    end_burst("mixed");

    repeat (3) @(posedge clk);
    if (pext_alu_inst.u_checks.fail_count == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("Finished with errors");
      $fatal(1, "Checks failed");
    end
  end

endmodule

// File: all.f
src/pext_op_pkg.sv
src/pext_lane_pkg.sv
src/pext_decoder.sv
src/pext_lane_adder.sv
src/pext_compare.sv
src/pext_shifter.sv
src/pext_permute.sv
src/pext_alu.sv
tests/tb_clock.sv
tests/pext_alu_assert.sv
tests/tb_pext_alu.sv
